//--- vlog.f
+incdir+tb
hdl/rv_decode_pkg.sv
hdl/op_type_decode.sv
hdl/imm_gen.sv
hdl/operand_select.sv
hdl/rv32_decoder.sv
tb/tb_decoder.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the decoder testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_decoder -Mdir obj_dir -f vlog.f \
    && ./obj_dir/Vtb_decoder > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation aborted"; exit 1; }

cat sim.log
grep -qF '** FAIL **' sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"

//--- tb/ref_decode.svh
`ifndef REF_DECODE_SVH
`define REF_DECODE_SVH

typedef struct packed {
    rv_decode_pkg::decoded_t dec;
    logic                    legal;                 // ack_o expected, else err_o
} expect_t;

logic [31:0] lfsr_state = 32'hbe1423b6;

// ==================================================
// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1
// ==================================================
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;

    v = '0;
    for (int k = 0; k < n; k++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v          = {v[30:0], fb};                 // One step per bit taken
    end
    return v;
endfunction

// ==================================================
// Expected decode, built from the ISA tables
// ==================================================
function automatic expect_t ref_decode(input rv_decode_pkg::instr_t i);
    expect_t                   e;
    rv_decode_pkg::instr_fmt_e fmt;
    rv_decode_pkg::op_type_e   op;
    rv_decode_pkg::op_type_e   br [8];
    rv_decode_pkg::op_type_e   ld [8];
    rv_decode_pkg::op_type_e   st [8];
    rv_decode_pkg::op_type_e   im [8];
    rv_decode_pkg::op_type_e   al [8];
    rv_decode_pkg::op_type_e   md [8];
    logic [2:0]                f3;
    logic [6:0]                f7;

    // Tables indexed by funct3
    br = '{rv_decode_pkg::OP_BEQ, rv_decode_pkg::OP_BNE, rv_decode_pkg::OP_NONE,
           rv_decode_pkg::OP_NONE, rv_decode_pkg::OP_BLT, rv_decode_pkg::OP_BGE,
           rv_decode_pkg::OP_BLTU, rv_decode_pkg::OP_BGEU};
    ld = '{rv_decode_pkg::OP_LB, rv_decode_pkg::OP_LH, rv_decode_pkg::OP_LW,
           rv_decode_pkg::OP_NONE, rv_decode_pkg::OP_LBU, rv_decode_pkg::OP_LHU,
           rv_decode_pkg::OP_NONE, rv_decode_pkg::OP_NONE};
    st = '{rv_decode_pkg::OP_SB, rv_decode_pkg::OP_SH, rv_decode_pkg::OP_SW,
           rv_decode_pkg::OP_NONE, rv_decode_pkg::OP_NONE, rv_decode_pkg::OP_NONE,
           rv_decode_pkg::OP_NONE, rv_decode_pkg::OP_NONE};
    im = '{rv_decode_pkg::OP_ADDI, rv_decode_pkg::OP_SLLI, rv_decode_pkg::OP_SLTI,
           rv_decode_pkg::OP_SLTIU, rv_decode_pkg::OP_XORI, rv_decode_pkg::OP_SRLI,
           rv_decode_pkg::OP_ORI, rv_decode_pkg::OP_ANDI};
    al = '{rv_decode_pkg::OP_ADD, rv_decode_pkg::OP_SLL, rv_decode_pkg::OP_SLT,
           rv_decode_pkg::OP_SLTU, rv_decode_pkg::OP_XOR, rv_decode_pkg::OP_SRL,
           rv_decode_pkg::OP_OR, rv_decode_pkg::OP_AND};
    md = '{rv_decode_pkg::OP_MUL, rv_decode_pkg::OP_MULH, rv_decode_pkg::OP_MULHSU,
           rv_decode_pkg::OP_MULHU, rv_decode_pkg::OP_DIV, rv_decode_pkg::OP_DIVU,
           rv_decode_pkg::OP_REM, rv_decode_pkg::OP_REMU};

    f3  = i[14:12];
    f7  = i[31:25];
    fmt = rv_decode_pkg::FMT_SYS;
    op  = rv_decode_pkg::OP_NONE;
    case (i[6:0])
        rv_decode_pkg::OPC_BRANCH: op = br[f3];
        rv_decode_pkg::OPC_LOAD:   op = ld[f3];
        rv_decode_pkg::OPC_STORE:  op = st[f3];
        rv_decode_pkg::OPC_LUI:    op = rv_decode_pkg::OP_LUI;
        rv_decode_pkg::OPC_AUIPC:  op = rv_decode_pkg::OP_AUIPC;
        rv_decode_pkg::OPC_JAL:    op = rv_decode_pkg::OP_JAL;
        rv_decode_pkg::OPC_JALR:   op = (f3 == 3'b000) ? rv_decode_pkg::OP_JALR : op;
        rv_decode_pkg::OPC_FENCE:  op = (f3 == 3'b000) ? rv_decode_pkg::OP_FENCE : op;
        rv_decode_pkg::OPC_OP_IMM: begin
            op = im[f3];
            if (f3 == 3'b101 && f7 == 7'h20) op = rv_decode_pkg::OP_SRAI;
            else if ((f3 == 3'b001 || f3 == 3'b101) && f7 != 7'h00) op = rv_decode_pkg::OP_NONE;
        end
        rv_decode_pkg::OPC_OP: begin
            if (f7 == 7'h00) op = al[f3];
            else if (f7 == 7'h01) op = md[f3];  // RV32M
            else if (f7 == 7'h20 && f3 == 3'b000) op = rv_decode_pkg::OP_SUB;
            else if (f7 == 7'h20 && f3 == 3'b101) op = rv_decode_pkg::OP_SRA;
        end
        rv_decode_pkg::OPC_SYSTEM: begin
            if (f3 == 3'b000) begin
                case (i[31:20])
                    12'h000: op = rv_decode_pkg::OP_ECALL;
                    12'h001: op = rv_decode_pkg::OP_EBREAK;
                    12'h302: op = rv_decode_pkg::OP_MRET;
                    12'h105: op = rv_decode_pkg::OP_WFI;
                    default: op = rv_decode_pkg::OP_NONE;
                endcase
            end
        end
        default: op = rv_decode_pkg::OP_NONE;
    endcase

    // Format follows the opcode alone
    case (i[6:0])
        rv_decode_pkg::OPC_OP:                           fmt = rv_decode_pkg::FMT_R;
        rv_decode_pkg::OPC_LOAD, rv_decode_pkg::OPC_OP_IMM,
        rv_decode_pkg::OPC_JALR, rv_decode_pkg::OPC_FENCE: fmt = rv_decode_pkg::FMT_I;
        rv_decode_pkg::OPC_STORE:                        fmt = rv_decode_pkg::FMT_S;
        rv_decode_pkg::OPC_BRANCH:                       fmt = rv_decode_pkg::FMT_B;
        rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC: fmt = rv_decode_pkg::FMT_U;
        rv_decode_pkg::OPC_JAL:                          fmt = rv_decode_pkg::FMT_J;
        default:                                         fmt = rv_decode_pkg::FMT_SYS;
    endcase

    e        = '0;
    e.legal  = (op != rv_decode_pkg::OP_NONE);
    e.dec.op = op;
    if (fmt inside {rv_decode_pkg::FMT_R, rv_decode_pkg::FMT_I, rv_decode_pkg::FMT_U,
                    rv_decode_pkg::FMT_J}) e.dec.rd = i[11:7];
    if (fmt inside {rv_decode_pkg::FMT_R, rv_decode_pkg::FMT_I, rv_decode_pkg::FMT_S,
                    rv_decode_pkg::FMT_B}) e.dec.rs1 = i[19:15];
    if (fmt inside {rv_decode_pkg::FMT_R, rv_decode_pkg::FMT_S,
                    rv_decode_pkg::FMT_B}) e.dec.rs2 = i[24:20];
    e.dec.load_rs = fmt inside {rv_decode_pkg::FMT_R, rv_decode_pkg::FMT_I,
                                rv_decode_pkg::FMT_S, rv_decode_pkg::FMT_B};
    case (fmt)
        rv_decode_pkg::FMT_I: e.dec.imm = 32'($signed(i[31:20]));
        rv_decode_pkg::FMT_S: e.dec.imm = 32'($signed({i[31:25], i[11:7]}));
        rv_decode_pkg::FMT_B: e.dec.imm = 32'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
        rv_decode_pkg::FMT_U: e.dec.imm = {i[31:12], 12'h000};
        rv_decode_pkg::FMT_J: e.dec.imm = 32'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
        default:              e.dec.imm = '0;
    endcase
    return e;
endfunction

`endif

//--- tb/tb_decoder.sv
module tb_decoder;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 2000;               // About 600 requests plus gaps

    logic                    clk_i;
    logic                    rst_i;
    logic                    stb_i;
    rv_decode_pkg::instr_t   instr_i;
    rv_decode_pkg::decoded_t decoded_o;
    logic                    ack_o;
    logic                    err_o;

    `include "ref_decode.svh"

    expect_t exp_q [$];                             // Oldest request first
    logic    prev_stb;
    int      cycles   = 0;
    int      n_req    = 0;
    int      n_checks = 0;
    int      errors   = 0;
    int      n_tests  = 0;
    int      err_mark = 0;

    rv32_decoder dut0 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stb_i     (stb_i),
        .instr_i   (instr_i),
        .decoded_o (decoded_o),
        .ack_o     (ack_o),
        .err_o     (err_o)
    );

    always #4 clk_i = ~clk_i;                       // 8 ns period

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s got 0x%h, expected 0x%h", $time, name, got, exp);
            errors++;
        end
    endtask

    // ==================================================
    // Monitor and compare
    // ==================================================
    always @(posedge clk_i) begin
        expect_t e;
        if (rst_i) begin
            prev_stb = 1'b0;
        end else begin
            check("ack_o|err_o", 32'(ack_o | err_o), 32'(prev_stb));  // One cycle after strobe
            if (ack_o || err_o) begin
                if (exp_q.size() == 0) begin
                    $display("Response at %0d ns arrived with no pending request", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check("ack_o", 32'(ack_o), 32'(e.legal));
                    check("err_o", 32'(err_o), 32'(!e.legal));
                    if (e.legal) begin
                        check("decoded_o.op", 32'(decoded_o.op), 32'(e.dec.op));
                        check("decoded_o.rd", 32'(decoded_o.rd), 32'(e.dec.rd));
                        check("decoded_o.rs1", 32'(decoded_o.rs1), 32'(e.dec.rs1));
                        check("decoded_o.rs2", 32'(decoded_o.rs2), 32'(e.dec.rs2));
                        check("decoded_o.imm", decoded_o.imm, e.dec.imm);
                        check("decoded_o.load_rs", 32'(decoded_o.load_rs), 32'(e.dec.load_rs));
                    end
                end
            end
            if (stb_i) begin
                exp_q.push_back(ref_decode(instr_i));
                n_req++;
            end
            prev_stb = stb_i;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d responses missing", cycles, exp_q.size());
            $display("** FAIL **");
            $finish;
        end
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================
    function automatic rv_decode_pkg::instr_t pack_fields(input logic [6:0] f7,
        input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3,
        input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic rv_decode_pkg::instr_t random_instr();
        logic [6:0]            opcodes [11];
        logic [6:0]            f7s [3];
        logic [11:0]           f12s [4];
        rv_decode_pkg::instr_t instr;
        logic [31:0]           bits;
        logic [3:0]            s4;
        logic [1:0]            s2;

        opcodes = '{rv_decode_pkg::OPC_BRANCH, rv_decode_pkg::OPC_LOAD, rv_decode_pkg::OPC_STORE,
                    rv_decode_pkg::OPC_OP_IMM, rv_decode_pkg::OPC_OP, rv_decode_pkg::OPC_SYSTEM,
                    rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC, rv_decode_pkg::OPC_JAL,
                    rv_decode_pkg::OPC_JALR, rv_decode_pkg::OPC_FENCE};
        f7s  = '{7'h00, 7'h20, 7'h01};
        f12s = '{12'h000, 12'h001, 12'h302, 12'h105};
        bits = rand_bits(25);
        s4   = 4'(rand_bits(4) % 32'd11);
        s2   = 2'(rand_bits(2));
        instr = {bits[24:0], opcodes[s4]};
        // Steer funct fields so most requests stay legal
        if ((opcodes[s4] == rv_decode_pkg::OPC_OP || opcodes[s4] == rv_decode_pkg::OPC_OP_IMM)
            && s2 != 2'd3) instr[31:25] = f7s[s2];
        if (opcodes[s4] == rv_decode_pkg::OPC_SYSTEM) begin
            instr[31:20] = f12s[s2];
            instr[14:12] = 3'b000;
        end
        return instr;
    endfunction

    task automatic issue(input rv_decode_pkg::instr_t instr);
        stb_i   = 1'b1;
        instr_i = instr;
        @(posedge clk_i);
        #1;
    endtask

    task automatic idle(input int n);
        stb_i = 1'b0;
        repeat (n) begin
            instr_i = rand_bits(32);                // Ignored without a strobe
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic close_test(input string name);
        stb_i = 1'b0;
        while (exp_q.size() != 0) @(posedge clk_i);
        #1;
        n_tests++;
        $display("Test %0d (%s) done with %0d errors", n_tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        clk_i   = 1'b0;
        rst_i   = 1'b1;
        stb_i   = 1'b0;
        instr_i = '0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        idle(3);                                    // Outputs stay low after reset
        // Result register cleared by reset and untouched while idle
        check("decoded_o.op", 32'(decoded_o.op), 32'd0);
        check("decoded_o.rd", 32'(decoded_o.rd), 32'd0);
        check("decoded_o.rs1", 32'(decoded_o.rs1), 32'd0);
        check("decoded_o.rs2", 32'(decoded_o.rs2), 32'd0);
        check("decoded_o.imm", decoded_o.imm, 32'd0);
        check("decoded_o.load_rs", 32'(decoded_o.load_rs), 32'd0);
        close_test("reset");

        issue(pack_fields(7'h43, 5'd7, 5'd9, 3'b001, 5'd21, rv_decode_pkg::OPC_BRANCH));
        issue(pack_fields(7'h7f, 5'd24, 5'd2, 3'b010, 5'd10, rv_decode_pkg::OPC_LOAD));
        issue(pack_fields(7'h02, 5'd11, 5'd3, 3'b001, 5'd4, rv_decode_pkg::OPC_STORE));
        issue(pack_fields(7'h41, 5'd5, 5'd1, 3'b000, 5'd6, rv_decode_pkg::OPC_OP_IMM));
        issue(pack_fields(7'h00, 5'd31, 5'd8, 3'b001, 5'd8, rv_decode_pkg::OPC_OP_IMM));
        issue(pack_fields(7'h00, 5'd3, 5'd9, 3'b101, 5'd12, rv_decode_pkg::OPC_OP_IMM));
        issue(pack_fields(7'h20, 5'd3, 5'd9, 3'b101, 5'd12, rv_decode_pkg::OPC_OP_IMM));
        issue(pack_fields(7'h20, 5'd12, 5'd13, 3'b000, 5'd14, rv_decode_pkg::OPC_OP));
        issue(pack_fields(7'h00, 5'd1, 5'd2, 3'b111, 5'd3, rv_decode_pkg::OPC_OP));
        issue(pack_fields(7'h55, 5'd17, 5'd18, 3'b011, 5'd19, rv_decode_pkg::OPC_LUI));
        issue(pack_fields(7'h2a, 5'd1, 5'd0, 3'b110, 5'd5, rv_decode_pkg::OPC_AUIPC));
        issue(pack_fields(7'h60, 5'd9, 5'd31, 3'b101, 5'd1, rv_decode_pkg::OPC_JAL));
        issue(pack_fields(7'h7f, 5'd28, 5'd6, 3'b000, 5'd1, rv_decode_pkg::OPC_JALR));
        issue(pack_fields(7'h07, 5'd31, 5'd0, 3'b000, 5'd0, rv_decode_pkg::OPC_FENCE));
        issue({12'h000, 13'h0, rv_decode_pkg::OPC_SYSTEM});  // ECALL
        issue({12'h001, 13'h0, rv_decode_pkg::OPC_SYSTEM});  // EBREAK
        issue({12'h302, 13'h0, rv_decode_pkg::OPC_SYSTEM});  // MRET
        issue({12'h105, 13'h0, rv_decode_pkg::OPC_SYSTEM});  // WFI
        close_test("directed");

        for (int f = 0; f < 8; f++) begin
            issue(pack_fields(7'h01, 5'(f + 3), 5'(f + 10), 3'(f), 5'(f + 20),
                              rv_decode_pkg::OPC_OP));
        end
        close_test("rv32m");

        issue(pack_fields(7'h00, 5'd1, 5'd2, 3'b000, 5'd3, 7'h5b));  // Unknown opcode
        issue(pack_fields(7'h00, 5'd0, 5'd1, 3'b011, 5'd2, rv_decode_pkg::OPC_LOAD));
        issue(pack_fields(7'h04, 5'd1, 5'd2, 3'b000, 5'd3, rv_decode_pkg::OPC_OP));
        issue(pack_fields(7'h20, 5'd1, 5'd1, 3'b001, 5'd1, rv_decode_pkg::OPC_OP_IMM));
        issue(pack_fields(7'h08, 5'd2, 5'd3, 3'b010, 5'd4, 7'h2f));  // AMO
        issue({12'h300, 5'd1, 3'b001, 5'd2, rv_decode_pkg::OPC_SYSTEM});  // CSRRW
        issue({12'h7ff, 13'h0, rv_decode_pkg::OPC_SYSTEM});
        close_test("illegal");

        repeat (500) issue(random_instr());
        close_test("random back-to-back");

        repeat (40) begin
            issue(random_instr());
            idle(int'(rand_bits(2)));
        end
        close_test("random with gaps");

        $display("Summary: %0d tests, %0d requests, %0d checks, %0d errors",
                 n_tests, n_req, n_checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- hdl/rv32_decoder.sv
module rv32_decoder (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    stb_i,
    input  rv_decode_pkg::instr_t   instr_i,
    output rv_decode_pkg::decoded_t decoded_o,
    output logic                    ack_o,
    output logic                    err_o
);

    rv_decode_pkg::op_type_e   op;
    rv_decode_pkg::instr_fmt_e fmt;
    logic                      illegal;
    rv_decode_pkg::imm_t       imm;
    rv_decode_pkg::reg_idx_t   rd;
    rv_decode_pkg::reg_idx_t   rs1;
    rv_decode_pkg::reg_idx_t   rs2;
    logic                      load_rs;
    rv_decode_pkg::decoded_t   result;

    // ==================================================
    // Combinational decode stages
    // ==================================================
    op_type_decode op_type_decode0 (
        .instr_i   (instr_i),
        .op_o      (op),
        .fmt_o     (fmt),
        .illegal_o (illegal)
    );

    imm_gen imm_gen0 (
        .instr_i (instr_i),
        .fmt_i   (fmt),
        .imm_o   (imm)
    );

    operand_select operand_select0 (
        .instr_i   (instr_i),
        .fmt_i     (fmt),
        .rd_o      (rd),
        .rs1_o     (rs1),
        .rs2_o     (rs2),
        .load_rs_o (load_rs)
    );

    assign result = '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm, load_rs: load_rs};

    // ==================================================
    // Result register and response
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            decoded_o <= '0;
            ack_o     <= 1'b0;
            err_o     <= 1'b0;
        end else begin
            ack_o <= stb_i & ~illegal;                 // One-cycle response
            err_o <= stb_i & illegal;
            if (stb_i) begin
                decoded_o <= result;                   // Held until the next strobe
            end
        end
    end

    // Responses never overlap
    a_ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(ack_o && err_o))
        else $error("rv32_decoder: ack_o and err_o high together");

    // No response without a strobe one cycle earlier
    a_no_stb_no_resp: assert property (@(posedge clk_i) disable iff (rst_i)
        !stb_i |=> !(ack_o || err_o))
        else $error("rv32_decoder: response without a preceding strobe");

endmodule

//--- hdl/operand_select.sv
module operand_select (
    input  rv_decode_pkg::instr_t     instr_i,
    input  rv_decode_pkg::instr_fmt_e fmt_i,
    output rv_decode_pkg::reg_idx_t   rd_o,
    output rv_decode_pkg::reg_idx_t   rs1_o,
    output rv_decode_pkg::reg_idx_t   rs2_o,
    output logic                      load_rs_o
);

    logic has_rd;
    logic has_rs1;
    logic has_rs2;

    // ==================================================
    // Which fields each format carries
    // ==================================================
    always_comb begin
        has_rd  = 1'b0;
        has_rs1 = 1'b0;
        has_rs2 = 1'b0;
        case (fmt_i)
            rv_decode_pkg::FMT_R: begin
                has_rd  = 1'b1;
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
            end
            rv_decode_pkg::FMT_I: begin
                has_rd  = 1'b1;
                has_rs1 = 1'b1;
            end
            rv_decode_pkg::FMT_S, rv_decode_pkg::FMT_B: begin
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
            end
            rv_decode_pkg::FMT_U, rv_decode_pkg::FMT_J: begin
                has_rd  = 1'b1;
            end
            default: begin                             // SYS uses no registers
            end
        endcase
    end

    assign rd_o      = has_rd  ? instr_i[11:7]  : '0;
    assign rs1_o     = has_rs1 ? instr_i[19:15] : '0;
    assign rs2_o     = has_rs2 ? instr_i[24:20] : '0;
    assign load_rs_o = has_rs1;                        // Every format with a source reads rs1

endmodule

//--- hdl/imm_gen.sv
module imm_gen (
    input  rv_decode_pkg::instr_t     instr_i,
    input  rv_decode_pkg::instr_fmt_e fmt_i,
    output rv_decode_pkg::imm_t       imm_o
);

    logic sign;

    assign sign = instr_i[31];

    // ==================================================
    // Immediate assembly per format
    // ==================================================
    always_comb begin
        case (fmt_i)
            rv_decode_pkg::FMT_I: begin                // Shifts keep funct7 bits too
                imm_o = {{(rv_decode_pkg::XLEN-12){sign}}, instr_i[31:20]};
            end
            rv_decode_pkg::FMT_S: begin
                imm_o = {{(rv_decode_pkg::XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            end
            rv_decode_pkg::FMT_B: begin
                imm_o = {{(rv_decode_pkg::XLEN-13){sign}}, sign, instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            end
            rv_decode_pkg::FMT_U: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            rv_decode_pkg::FMT_J: begin
                imm_o = {{(rv_decode_pkg::XLEN-21){sign}}, sign, instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            default: begin                             // R and SYS have no immediate
                imm_o = '0;
            end
        endcase
    end

endmodule

//--- hdl/op_type_decode.sv
module op_type_decode (
    input  rv_decode_pkg::instr_t     instr_i,
    output rv_decode_pkg::op_type_e   op_o,
    output rv_decode_pkg::instr_fmt_e fmt_o,
    output logic                      illegal_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign funct7  = instr_i[31:25];
    assign funct12 = instr_i[31:20];

    // ==================================================
    // Opcode / funct case tree
    // ==================================================
    always_comb begin
        op_o      = rv_decode_pkg::OP_NONE;
        fmt_o     = rv_decode_pkg::FMT_SYS;
        illegal_o = 1'b0;

        case (opcode)
            rv_decode_pkg::OPC_BRANCH: begin
                fmt_o = rv_decode_pkg::FMT_B;
                case (funct3)
                    3'b000: op_o = rv_decode_pkg::OP_BEQ;
                    3'b001: op_o = rv_decode_pkg::OP_BNE;
                    3'b100: op_o = rv_decode_pkg::OP_BLT;
                    3'b101: op_o = rv_decode_pkg::OP_BGE;
                    3'b110: op_o = rv_decode_pkg::OP_BLTU;
                    3'b111: op_o = rv_decode_pkg::OP_BGEU;
                    default: illegal_o = 1'b1;
                endcase
            end

            rv_decode_pkg::OPC_LOAD: begin
                fmt_o = rv_decode_pkg::FMT_I;
                case (funct3)
                    3'b000: op_o = rv_decode_pkg::OP_LB;
                    3'b001: op_o = rv_decode_pkg::OP_LH;
                    3'b010: op_o = rv_decode_pkg::OP_LW;
                    3'b100: op_o = rv_decode_pkg::OP_LBU;
                    3'b101: op_o = rv_decode_pkg::OP_LHU;
                    default: illegal_o = 1'b1;
                endcase
            end

            rv_decode_pkg::OPC_STORE: begin
                fmt_o = rv_decode_pkg::FMT_S;
                case (funct3)
                    3'b000: op_o = rv_decode_pkg::OP_SB;
                    3'b001: op_o = rv_decode_pkg::OP_SH;
                    3'b010: op_o = rv_decode_pkg::OP_SW;
                    default: illegal_o = 1'b1;
                endcase
            end

            rv_decode_pkg::OPC_OP_IMM: begin
                fmt_o = rv_decode_pkg::FMT_I;
                case (funct3)
                    3'b000: op_o = rv_decode_pkg::OP_ADDI;
                    3'b010: op_o = rv_decode_pkg::OP_SLTI;
                    3'b011: op_o = rv_decode_pkg::OP_SLTIU;
                    3'b100: op_o = rv_decode_pkg::OP_XORI;
                    3'b110: op_o = rv_decode_pkg::OP_ORI;
                    3'b111: op_o = rv_decode_pkg::OP_ANDI;
                    3'b001: begin
                        if (funct7 == rv_decode_pkg::F7_BASE) op_o = rv_decode_pkg::OP_SLLI;
                        else illegal_o = 1'b1;     // Also catches shamt[5]
                    end
                    default: begin                 // 3'b101
                        if (funct7 == rv_decode_pkg::F7_BASE) op_o = rv_decode_pkg::OP_SRLI;
                        else if (funct7 == rv_decode_pkg::F7_ALT) op_o = rv_decode_pkg::OP_SRAI;
                        else illegal_o = 1'b1;
                    end
                endcase
            end

            rv_decode_pkg::OPC_OP: begin
                fmt_o = rv_decode_pkg::FMT_R;
                case (funct7)
                    rv_decode_pkg::F7_BASE: begin
                        case (funct3)
                            3'b000: op_o = rv_decode_pkg::OP_ADD;
                            3'b001: op_o = rv_decode_pkg::OP_SLL;
                            3'b010: op_o = rv_decode_pkg::OP_SLT;
                            3'b011: op_o = rv_decode_pkg::OP_SLTU;
                            3'b100: op_o = rv_decode_pkg::OP_XOR;
                            3'b101: op_o = rv_decode_pkg::OP_SRL;
                            3'b110: op_o = rv_decode_pkg::OP_OR;
                            default: op_o = rv_decode_pkg::OP_AND;
                        endcase
                    end
                    rv_decode_pkg::F7_ALT: begin
                        if (funct3 == 3'b000) op_o = rv_decode_pkg::OP_SUB;
                        else if (funct3 == 3'b101) op_o = rv_decode_pkg::OP_SRA;
                        else illegal_o = 1'b1;
                    end
                    rv_decode_pkg::F7_MULDIV: begin
                        case (funct3)
                            3'b000: op_o = rv_decode_pkg::OP_MUL;
                            3'b001: op_o = rv_decode_pkg::OP_MULH;
                            3'b010: op_o = rv_decode_pkg::OP_MULHSU;
                            3'b011: op_o = rv_decode_pkg::OP_MULHU;
                            3'b100: op_o = rv_decode_pkg::OP_DIV;
                            3'b101: op_o = rv_decode_pkg::OP_DIVU;
                            3'b110: op_o = rv_decode_pkg::OP_REM;
                            default: op_o = rv_decode_pkg::OP_REMU;
                        endcase
                    end
                    default: illegal_o = 1'b1;
                endcase
            end

            rv_decode_pkg::OPC_SYSTEM: begin
                fmt_o = rv_decode_pkg::FMT_SYS;
                if (funct3 != 3'b000) begin
                    illegal_o = 1'b1;              // CSR space is not decoded
                end else begin
                    case (funct12)
                        rv_decode_pkg::F12_ECALL:  op_o = rv_decode_pkg::OP_ECALL;
                        rv_decode_pkg::F12_EBREAK: op_o = rv_decode_pkg::OP_EBREAK;
                        rv_decode_pkg::F12_MRET:   op_o = rv_decode_pkg::OP_MRET;
                        rv_decode_pkg::F12_WFI:    op_o = rv_decode_pkg::OP_WFI;
                        default: illegal_o = 1'b1;
                    endcase
                end
            end

            rv_decode_pkg::OPC_LUI: begin
                fmt_o = rv_decode_pkg::FMT_U;
                op_o  = rv_decode_pkg::OP_LUI;
            end

            rv_decode_pkg::OPC_AUIPC: begin
                fmt_o = rv_decode_pkg::FMT_U;
                op_o  = rv_decode_pkg::OP_AUIPC;
            end

            rv_decode_pkg::OPC_JAL: begin
                fmt_o = rv_decode_pkg::FMT_J;
                op_o  = rv_decode_pkg::OP_JAL;
            end

            rv_decode_pkg::OPC_JALR: begin
                fmt_o = rv_decode_pkg::FMT_I;
                if (funct3 == 3'b000) op_o = rv_decode_pkg::OP_JALR;
                else illegal_o = 1'b1;
            end

            rv_decode_pkg::OPC_FENCE: begin
                fmt_o = rv_decode_pkg::FMT_I;      // pred/succ travel in the immediate
                if (funct3 == 3'b000) op_o = rv_decode_pkg::OP_FENCE;
                else illegal_o = 1'b1;
            end

            default: illegal_o = 1'b1;             // Includes AMO and compressed space
        endcase

        // Every legal leaf of the tree must name an operation
        a_op_matches_illegal: assert (illegal_o == (op_o == rv_decode_pkg::OP_NONE))
            else $error("op_type_decode: op %0d and illegal %0b disagree", op_o, illegal_o);
    end

endmodule

//--- hdl/rv_decode_pkg.sv
package rv_decode_pkg;

    // ==================================================
    // Widths and raw types
    // ==================================================
    localparam int XLEN      = 32;                 // Instruction and immediate width
    localparam int REG_IDX_W = 5;                  // x0..x31

    typedef logic [XLEN-1:0]      instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [XLEN-1:0]      imm_t;

    // ==================================================
    // Encoding constants
    // ==================================================
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // SUB, SRA, SRAI
    localparam logic [6:0] F7_MULDIV = 7'b0000001; // RV32M

    localparam logic [11:0] F12_ECALL  = 12'b0000000_00000;
    localparam logic [11:0] F12_EBREAK = 12'b0000000_00001;
    localparam logic [11:0] F12_MRET   = 12'b0011000_00010;
    localparam logic [11:0] F12_WFI    = 12'b0001000_00101;

    // ==================================================
    // Decoded operation and format
    // ==================================================
    typedef enum logic [6:0] {
        OP_NONE = 7'd0,                            // Illegal encoding
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU,
        OP_FENCE, OP_ECALL, OP_EBREAK, OP_MRET, OP_WFI
    } op_type_e;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_SYS                                    // No register or immediate fields
    } instr_fmt_e;

    typedef struct packed {
        op_type_e op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        imm_t     imm;
        logic     load_rs;                         // rs1/rs2 must be read from the regfile
    } decoded_t;

endpackage
